//--- verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int XLEN           = 32;
    localparam int TAG_WIDTH      = 5;     // tag 0 means value present
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 1 << REG_ADDR_WIDTH;

    // instruction word field positions
    localparam int OPC_HI  = 31;
    localparam int OPC_LO  = 28;
    localparam int IMM_SEL = 27;
    localparam int RD_HI   = 26;
    localparam int RD_LO   = 22;
    localparam int RS1_HI  = 21;
    localparam int RS1_LO  = 17;
    localparam int RS2_HI  = 16;
    localparam int RS2_LO  = 12;
    localparam int IMM_HI  = 11;           // signed immediate
    localparam int IMM_LO  = 0;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_mul = 4'd5
    } opcode_t;

    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_kind_t;

    typedef struct packed {
        logic            valid;
        opcode_t         op;
        fu_kind_t        fu;
        logic            op1_ready;
        logic            op2_ready;
        logic [XLEN-1:0] op1;          // value, or tag in the low bits
        logic [XLEN-1:0] op2;
        tag_t            dest_tag;
    } rs_entry_t;

    typedef struct packed {
        logic            valid;
        opcode_t         op;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        tag_t            dest_tag;
    } issue_pkt_t;

    typedef struct packed {
        logic            valid;
        tag_t            tag;
        logic [XLEN-1:0] value;
    } cdb_t;

endpackage

`default_nettype wire

//--- verilog/issue_if.sv
`timescale 1ns/1ns
`default_nettype none

interface issue_if;
    import ooo_pkg::*;

    issue_pkt_t alu_pkt;
    issue_pkt_t mult_pkt;
    logic       alu_avail;
    logic       mult_avail;

    modport rs (
        output alu_pkt,
        output mult_pkt,
        input  alu_avail,
        input  mult_avail
    );

    modport exec (
        input  alu_pkt,
        input  mult_pkt,
        output alu_avail,
        output mult_avail
    );

endinterface

`default_nettype wire

//--- verilog/dispatch_decode.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_decode (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire logic                               in_valid,
    input  wire logic [31:0]                        in_word,
    input  wire logic                               almost_full,
    input  wire ooo_pkg::cdb_t                      cdb,
    input  wire logic [ooo_pkg::REG_ADDR_WIDTH-1:0] rf_raddr,
    output logic                                    in_ready,
    output ooo_pkg::rs_entry_t                      dispatch_entry,
    output logic [ooo_pkg::XLEN-1:0]                rf_rdata
);
    import ooo_pkg::*;

    logic [XLEN-1:0]           rf [NUM_REGS];
    tag_t                      reg_tag [NUM_REGS];
    tag_t                      tag_ctr;
    opcode_t                   op;
    logic                      use_imm;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic [XLEN-1:0]           imm_ext;
    logic [XLEN:0]             src1;      // {ready, value or tag}
    logic [XLEN:0]             src2;
    logic                      fire;
    logic                      cdb_hit;
    rs_entry_t                 next_entry;

    function automatic logic [XLEN:0] read_src(input logic [REG_ADDR_WIDTH-1:0] r);
        if (r == '0) begin
            return {1'b1, {XLEN{1'b0}}};
        end
        if (reg_tag[r] == '0) begin
            return {1'b1, rf[r]};
        end
        if (cdb_hit && cdb.tag == reg_tag[r]) begin
            return {1'b1, cdb.value};                // bypass
        end
        return {1'b0, {(XLEN-TAG_WIDTH){1'b0}}, reg_tag[r]};
    endfunction

    assign in_ready = ~almost_full;
    assign fire     = in_valid & in_ready;
    assign cdb_hit  = cdb.valid && cdb.tag != '0;

    assign op      = opcode_t'(in_word[OPC_HI:OPC_LO]);
    assign use_imm = in_word[IMM_SEL];
    assign rd      = in_word[RD_HI:RD_LO];
    assign rs1     = in_word[RS1_HI:RS1_LO];
    assign rs2     = in_word[RS2_HI:RS2_LO];
    assign imm_ext = {{(XLEN-IMM_HI-1){in_word[IMM_HI]}}, in_word[IMM_HI:IMM_LO]};

    always_comb begin
        src1                 = read_src(rs1);
        src2                 = read_src(rs2);
        next_entry.valid     = fire;
        next_entry.op        = op;
        next_entry.fu        = (op == op_mul) ? fu_mult : fu_alu;
        next_entry.op1_ready = src1[XLEN];
        next_entry.op1       = src1[XLEN-1:0];
        next_entry.op2_ready = use_imm | src2[XLEN];
        next_entry.op2       = use_imm ? imm_ext : src2[XLEN-1:0];
        next_entry.dest_tag  = (rd == '0) ? '0 : tag_ctr;   // r0 never renamed
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tag_ctr        <= tag_t'(1);
            dispatch_entry <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                reg_tag[i] <= '0;
            end
        end else begin
            dispatch_entry <= next_entry;
            for (int i = 1; i < NUM_REGS; i++) begin
                if (cdb_hit && reg_tag[i] == cdb.tag) begin
                    reg_tag[i] <= '0;
                end
            end
            if (fire && rd != '0) begin
                reg_tag[rd] <= tag_ctr;                  // rename beats release
                tag_ctr     <= (tag_ctr == '1) ? tag_t'(1) : tag_ctr + 1'b1;
            end
        end
    end

    // only the newest producer of a register may write it
    always_ff @(posedge clock) begin
        for (int i = 1; i < NUM_REGS; i++) begin
            if (cdb_hit && reg_tag[i] == cdb.tag) begin
                rf[i] <= cdb.value;
            end
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr];

    a_known_opcode: assert property (@(posedge clock) disable iff (reset)
        fire |-> ##1 (dispatch_entry.valid &&
                      dispatch_entry.op inside {op_add, op_sub, op_and, op_or, op_xor, op_mul}));

endmodule

`default_nettype wire

//--- verilog/reservation_station.sv
`timescale 1ns/1ns
`default_nettype none

module reservation_station #(
    parameter int RS_SIZE     = 8,
    parameter int ALERT_DEPTH = 1
) (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire ooo_pkg::rs_entry_t dispatch_entry,
    input  wire ooo_pkg::cdb_t      cdb,
    issue_if.rs                     iss,
    output logic                    almost_full,
    output logic                    empty
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(RS_SIZE + 1);
    localparam int IDX_W = $clog2(RS_SIZE);

    rs_entry_t          entries      [RS_SIZE];
    rs_entry_t          next_entries [RS_SIZE];
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   next_count;
    logic [CNT_W:0]     occupancy;
    logic [RS_SIZE-1:0] ready;
    logic               inserted;
    logic               alu_fire;
    logic               mult_fire;
    logic [IDX_W-1:0]   alu_idx;
    logic [IDX_W-1:0]   mult_idx;
    issue_pkt_t         next_alu_pkt;
    issue_pkt_t         next_mult_pkt;

    function automatic issue_pkt_t to_pkt(input rs_entry_t e);
        issue_pkt_t p;
        p.valid    = e.valid;
        p.op       = e.op;
        p.op1      = e.op1;
        p.op2      = e.op2;
        p.dest_tag = e.dest_tag;
        return p;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            ready[i] = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready;
        end
    end

    // lowest index wins, walk down so the last hit sticks
    always_comb begin
        alu_fire  = 1'b0;
        mult_fire = 1'b0;
        alu_idx   = '0;
        mult_idx  = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (ready[i] && entries[i].fu == fu_alu) begin
                alu_fire = iss.alu_avail;
                alu_idx  = IDX_W'(i);
            end
        end
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (ready[i] && entries[i].fu == fu_mult) begin
                mult_fire = iss.mult_avail;
                mult_idx  = IDX_W'(i);
            end
        end
    end

    always_comb begin
        next_entries = entries;
        inserted     = 1'b0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (dispatch_entry.valid && !entries[i].valid && !inserted) begin
                next_entries[i] = dispatch_entry;       // lowest free slot
                inserted        = 1'b1;
            end
            if (cdb.valid && next_entries[i].valid) begin
                if (!next_entries[i].op1_ready &&
                    next_entries[i].op1[TAG_WIDTH-1:0] == cdb.tag) begin
                    next_entries[i].op1_ready = 1'b1;
                    next_entries[i].op1       = cdb.value;
                end
                if (!next_entries[i].op2_ready &&
                    next_entries[i].op2[TAG_WIDTH-1:0] == cdb.tag) begin
                    next_entries[i].op2_ready = 1'b1;
                    next_entries[i].op2       = cdb.value;
                end
            end
        end
        next_alu_pkt  = '0;
        next_mult_pkt = '0;
        if (alu_fire) begin
            next_alu_pkt                 = to_pkt(entries[alu_idx]);
            next_entries[alu_idx].valid  = 1'b0;
        end
        if (mult_fire) begin
            next_mult_pkt                = to_pkt(entries[mult_idx]);
            next_entries[mult_idx].valid = 1'b0;
        end
        next_count = count + CNT_W'(inserted) - CNT_W'(alu_fire) - CNT_W'(mult_fire);
    end

    // the entry still sitting in decode's register counts as taken
    assign occupancy   = {1'b0, count} + (CNT_W+1)'(dispatch_entry.valid);
    assign almost_full = occupancy > (CNT_W+1)'(RS_SIZE - ALERT_DEPTH);
    assign empty       = (count == '0) && !dispatch_entry.valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            count        <= '0;
            iss.alu_pkt  <= '0;
            iss.mult_pkt <= '0;
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i] <= '0;
            end
        end else begin
            count        <= next_count;
            entries      <= next_entries;
            iss.alu_pkt  <= next_alu_pkt;
            iss.mult_pkt <= next_mult_pkt;
        end
    end

    a_alu_issue_ready: assert property (@(posedge clock) disable iff (reset)
        iss.alu_pkt.valid |-> $past(entries[alu_idx].op1_ready && entries[alu_idx].op2_ready));

    a_mult_issue_ready: assert property (@(posedge clock) disable iff (reset)
        iss.mult_pkt.valid |->
            $past(entries[mult_idx].op1_ready && entries[mult_idx].op2_ready));

    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= CNT_W'(RS_SIZE));

endmodule

`default_nettype wire

//--- verilog/exec_units.sv
`timescale 1ns/1ns
`default_nettype none

module exec_units (
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire logic     alu_stall,
    issue_if.exec         iss,
    output ooo_pkg::cdb_t alu_done,
    output ooo_pkg::cdb_t mult_done,
    output logic          busy
);
    import ooo_pkg::*;

    localparam int HALF = XLEN / 2;

    logic [XLEN-1:0] alu_result;
    logic            s1_valid;
    tag_t            s1_tag;
    logic [XLEN-1:0] s1_a;
    logic [XLEN-1:0] s1_b;
    logic            s2_valid;
    tag_t            s2_tag;
    logic [XLEN-1:0] s2_lo;       // a * b[15:0]
    logic [HALF-1:0] s2_hi;       // a[15:0] * b[31:16], low half only

    always_comb begin
        case (iss.alu_pkt.op)
            op_add:  alu_result = iss.alu_pkt.op1 + iss.alu_pkt.op2;
            op_sub:  alu_result = iss.alu_pkt.op1 - iss.alu_pkt.op2;
            op_and:  alu_result = iss.alu_pkt.op1 & iss.alu_pkt.op2;
            op_or:   alu_result = iss.alu_pkt.op1 | iss.alu_pkt.op2;
            op_xor:  alu_result = iss.alu_pkt.op1 ^ iss.alu_pkt.op2;
            default: alu_result = '0;
        endcase
    end

    // a conflict this cycle fills the result hold next cycle
    assign iss.alu_avail  = !(alu_stall || (alu_done.valid && mult_done.valid));
    assign iss.mult_avail = 1'b1;     // fixed latency, never blocked

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_done <= '0;
        end else if (!alu_stall) begin
            alu_done.valid <= iss.alu_pkt.valid && iss.alu_pkt.dest_tag != '0;
            alu_done.tag   <= iss.alu_pkt.dest_tag;
            alu_done.value <= alu_result;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            mult_done <= '0;
        end else begin
            s1_valid        <= iss.mult_pkt.valid && iss.mult_pkt.dest_tag != '0;
            s2_valid        <= s1_valid;
            mult_done.valid <= s2_valid;
            mult_done.tag   <= s2_tag;
            mult_done.value <= s2_lo + {s2_hi, {HALF{1'b0}}};
        end
    end

    always_ff @(posedge clock) begin
        s1_tag <= iss.mult_pkt.dest_tag;
        s1_a   <= iss.mult_pkt.op1;
        s1_b   <= iss.mult_pkt.op2;
        s2_tag <= s1_tag;
        s2_lo  <= s1_a * {{HALF{1'b0}}, s1_b[HALF-1:0]};
        s2_hi  <= s1_a[HALF-1:0] * s1_b[XLEN-1:HALF];
    end

    assign busy = iss.alu_pkt.valid | iss.mult_pkt.valid | alu_done.valid |
                  s1_valid | s2_valid | mult_done.valid;

    // issue was granted a cycle earlier, so the result register must be free now
    a_alu_not_held: assert property (@(posedge clock) disable iff (reset)
        iss.alu_pkt.valid |-> ($past(iss.alu_avail) && !alu_stall));

endmodule

`default_nettype wire

//--- verilog/result_bus.sv
`timescale 1ns/1ns
`default_nettype none

module result_bus (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire ooo_pkg::cdb_t alu_done,
    input  wire ooo_pkg::cdb_t mult_done,
    input  wire logic          rs_empty,
    input  wire logic          exec_busy,
    output ooo_pkg::cdb_t      cdb,
    output logic               alu_stall,
    output logic               idle
);
    import ooo_pkg::*;

    cdb_t hold;
    cdb_t next_hold;
    cdb_t next_cdb;

    always_comb begin
        next_cdb  = '0;
        next_hold = hold;
        if (mult_done.valid) begin
            next_cdb = mult_done;                 // multiplier always wins
            if (!hold.valid && alu_done.valid) begin
                next_hold = alu_done;             // park the loser
            end
        end else if (hold.valid) begin
            next_cdb        = hold;
            next_hold.valid = 1'b0;
        end else if (alu_done.valid) begin
            next_cdb = alu_done;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb  <= '0;
            hold <= '0;
        end else begin
            cdb  <= next_cdb;
            hold <= next_hold;
        end
    end

    assign alu_stall = hold.valid;
    assign idle      = rs_empty && !exec_busy && !hold.valid && !cdb.valid;

    a_cdb_live_tag: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (cdb.tag != '0 &&
                       $past(alu_done.valid || mult_done.valid || hold.valid)));

endmodule

`default_nettype wire

//--- verilog/ooo_slice_top.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_slice_top #(
    parameter int RS_SIZE     = 8,
    parameter int ALERT_DEPTH = 1
) (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire logic                               in_valid,
    input  wire logic [31:0]                        in_word,
    output logic                                    in_ready,
    input  wire logic [ooo_pkg::REG_ADDR_WIDTH-1:0] rf_raddr,
    output logic [ooo_pkg::XLEN-1:0]                rf_rdata,
    output logic                                    cdb_valid,
    output logic [ooo_pkg::TAG_WIDTH-1:0]           cdb_tag,
    output logic [ooo_pkg::XLEN-1:0]                cdb_value,
    output logic                                    idle
);
    import ooo_pkg::*;

    rs_entry_t dispatch_entry;
    logic      almost_full;
    logic      rs_empty;
    logic      alu_stall;
    logic      exec_busy;
    cdb_t      alu_done;
    cdb_t      mult_done;
    cdb_t      cdb;

    issue_if iss ();

    dispatch_decode i_decode (
        .clock          (clock),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_word        (in_word),
        .almost_full    (almost_full),
        .cdb            (cdb),
        .rf_raddr       (rf_raddr),
        .in_ready       (in_ready),
        .dispatch_entry (dispatch_entry),
        .rf_rdata       (rf_rdata)
    );

    reservation_station #(
        .RS_SIZE     (RS_SIZE),
        .ALERT_DEPTH (ALERT_DEPTH)
    ) i_rs (
        .clock          (clock),
        .reset          (reset),
        .dispatch_entry (dispatch_entry),
        .cdb            (cdb),
        .iss            (iss.rs),
        .almost_full    (almost_full),
        .empty          (rs_empty)
    );

    exec_units i_exec (
        .clock     (clock),
        .reset     (reset),
        .alu_stall (alu_stall),
        .iss       (iss.exec),
        .alu_done  (alu_done),
        .mult_done (mult_done),
        .busy      (exec_busy)
    );

    result_bus i_result (
        .clock     (clock),
        .reset     (reset),
        .alu_done  (alu_done),
        .mult_done (mult_done),
        .rs_empty  (rs_empty),
        .exec_busy (exec_busy),
        .cdb       (cdb),
        .alu_stall (alu_stall),
        .idle      (idle)
    );

    assign cdb_valid = cdb.valid;
    assign cdb_tag   = cdb.tag;
    assign cdb_value = cdb.value;

endmodule

`default_nettype wire

//--- testbench/tb_ooo_slice.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ooo_slice;
    import ooo_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic        clock;
    logic        reset;
    logic        in_valid;
    logic [31:0] in_word;
    logic        in_ready;
    logic [4:0]  rf_raddr;
    logic [31:0] rf_rdata;
    logic        cdb_valid;
    logic [4:0]  cdb_tag;
    logic [31:0] cdb_value;
    logic        idle;

    logic [31:0] model_rf [32];     // architectural state in program order
    logic [31:0] pending_values [$];    // predicted results not yet seen on the cdb
    int          error_count;
    int          cdb_count;
    int          expected_cdb;
    logic        stall_seen;

    ooo_slice_top #(
        .RS_SIZE     (8),
        .ALERT_DEPTH (1)
    ) i_dut (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_ready  (in_ready),
        .rf_raddr  (rf_raddr),
        .rf_rdata  (rf_rdata),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .idle      (idle)
    );

    always #2 clock = ~clock;

    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            cdb_count = cdb_count + 1;      // one result per valid cycle
            match_cdb_result(cdb_tag, cdb_value);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // each broadcast retires one predicted result
    task automatic match_cdb_result(input logic [4:0] tag, input logic [31:0] value);
        int hit;
        hit = -1;
        if (tag == 5'd0) begin
            error_count = error_count + 1;
            $display("cdb broadcast a result with tag 0, value %h", value);
        end
        foreach (pending_values[i]) begin
            if (hit < 0 && pending_values[i] === value) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            error_count = error_count + 1;
            $display("cdb value %h on tag %0d matches no outstanding result", value, tag);
        end else begin
            pending_values.delete(hit);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("errors: %0d", error_count + 1);
        $display("Verification failed");
        $finish;
    endtask

    function automatic logic [31:0] make_word(input opcode_t op, input logic use_imm,
                                              input int rd, input int rs1, input int rs2,
                                              input int imm);
        logic [31:0] w;
        w                 = '0;
        w[OPC_HI:OPC_LO]  = op;
        w[IMM_SEL]        = use_imm;
        w[RD_HI:RD_LO]    = rd[4:0];
        w[RS1_HI:RS1_LO]  = rs1[4:0];
        w[RS2_HI:RS2_LO]  = rs2[4:0];
        w[IMM_HI:IMM_LO]  = imm[11:0];
        return w;
    endfunction

    function automatic logic [31:0] model_result(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        a = model_rf[w[RS1_HI:RS1_LO]];
        b = w[IMM_SEL] ? {{20{w[IMM_HI]}}, w[IMM_HI:IMM_LO]} : model_rf[w[RS2_HI:RS2_LO]];
        case (opcode_t'(w[OPC_HI:OPC_LO]))
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_mul:  return a * b;          // low half of the product
            default: return '0;
        endcase
    endfunction

    task automatic apply_model(input logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] result;
        rd = w[RD_HI:RD_LO];
        if (rd != 5'd0) begin
            result       = model_result(w);
            model_rf[rd] = result;
            pending_values.push_back(result);
            expected_cdb = expected_cdb + 1;
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_word(input logic [31:0] w);
        int cycles;
        cycles   = 0;
        in_valid = 1'b1;
        in_word  = w;
        while (!in_ready) begin
            stall_seen = 1'b1;
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_timeout("in_ready");
            end
        end
        @(posedge clock);
        apply_model(w);
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic imm_op(input opcode_t op, input int rd, input int rs1, input int imm);
        send_word(make_word(op, 1'b1, rd, rs1, 0, imm));
    endtask

    task automatic reg_op(input opcode_t op, input int rd, input int rs1, input int rs2);
        send_word(make_word(op, 1'b0, rd, rs1, rs2, 0));
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        while (!idle) begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_timeout({"idle in ", name});
            end
        end
    endtask

    task automatic check_regs(input string name);
        for (int r = 0; r < 32; r++) begin
            rf_raddr = 5'(r);
            #1;
            check_value($sformatf("%s r%0d", name, r), model_rf[r], rf_rdata);
            @(negedge clock);
        end
    endtask

    task automatic init_registers();
        for (int r = 1; r < 32; r++) begin
            imm_op(op_add, r, 0, r * 211 - 1500);
        end
        wait_idle("init");
        check_regs("init");
    endtask

    task automatic test_independent_alu();
        imm_op(op_add, 1, 2, 100);
        imm_op(op_sub, 3, 4, 25);
        imm_op(op_and, 15, 16, 'h0f0);
        imm_op(op_or, 17, 18, -3);
        imm_op(op_xor, 19, 20, 'h555);
        wait_idle("independent_alu");
        check_regs("independent_alu");
    endtask

    task automatic test_dependency_chain();
        imm_op(op_add, 6, 1, 100);
        for (int i = 0; i < 4; i++) begin
            imm_op(op_add, 23 + i, 27 + i, i + 1);  // r6 reaches the cdb as the mul decodes
        end
        reg_op(op_mul, 7, 6, 2);            // r6 from the decode bypass
        reg_op(op_sub, 8, 7, 6);            // waits on r7 tag
        imm_op(op_xor, 9, 8, 'h3c3);
        reg_op(op_add, 10, 9, 7);
        reg_op(op_or, 11, 10, 8);
        wait_idle("dependency_chain");
        check_regs("dependency_chain");
    endtask

    task automatic test_write_after_write();
        reg_op(op_mul, 5, 3, 4);            // finishes after the add below
        imm_op(op_add, 5, 1, 7);
        reg_op(op_add, 21, 5, 5);
        wait_idle("write_after_write");
        check_regs("write_after_write");
    endtask

    task automatic test_backpressure();
        stall_seen = 1'b0;
        for (int i = 0; i < 4; i++) begin
            reg_op(op_mul, 12, 12, 2);
        end
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0) begin
                reg_op(op_add, 13, 13, 12);
            end else begin
                reg_op(op_xor, 13, 13, 12);
            end
        end
        wait_idle("backpressure");
        check_value("backpressure in_ready low", 32'd1, {31'd0, stall_seen});
        check_regs("backpressure");
    endtask

    task automatic test_register_zero();
        imm_op(op_add, 0, 1, 55);
        reg_op(op_mul, 0, 2, 3);
        reg_op(op_add, 22, 0, 1);           // r0 source reads zero
        wait_idle("register_zero");
        check_regs("register_zero");
    endtask

    task automatic test_random_program();
        logic [31:0] w;
        for (int i = 0; i < 40; i++) begin
            w                = $urandom();
            w[OPC_HI:OPC_LO] = 4'($urandom_range(5, 0));
            send_word(w);
        end
        wait_idle("random_program");
        check_regs("random_program");
    endtask

    initial begin
        void'($urandom(54));
        clock        = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_word      = '0;
        rf_raddr     = '0;
        error_count  = 0;
        cdb_count    = 0;
        expected_cdb = 0;
        stall_seen   = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_rf[r] = '0;
        end
        repeat (3) @(negedge clock);
        reset = 1'b0;
        check_value("reset in_ready", 32'd1, {31'd0, in_ready});
        check_value("reset idle", 32'd1, {31'd0, idle});
        check_value("reset cdb_valid", 32'd0, {31'd0, cdb_valid});
        init_registers();
        test_independent_alu();
        test_dependency_chain();
        test_write_after_write();
        test_backpressure();
        test_register_zero();
        test_random_program();
        check_value("cdb pulse count", expected_cdb, cdb_count);
        $display("errors: %0d, cdb results: %0d", error_count, cdb_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/ooo_pkg.sv
verilog/issue_if.sv
verilog/dispatch_decode.sv
verilog/reservation_station.sv
verilog/exec_units.sv
verilog/result_bus.sv
verilog/ooo_slice_top.sv
testbench/tb_ooo_slice.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_slice
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Verification passed

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation result found in $(LOG)"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
